// ==== flist.f ====
+incdir+hdl
+incdir+test
hdl/decodePkg.sv
hdl/systemDecode.sv
hdl/intAluDecode.sv
hdl/flowMemDecode.sv
hdl/pipeStageReg.sv
hdl/controlPipe.sv
test/tb_controlPipe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_controlPipe -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// ==== test/controlTable.svh ====
`ifndef CONTROL_TABLE_SVH
`define CONTROL_TABLE_SVH

// Each row holds an instruction word and its expected bundle, built by
// ctl({ecall, ebreak, invInstr}, origA, origB, {regWrite, csRegWrite, memWrite, memRead},
//     mem2Reg, origPc, aluControl, instrType); expected fields come from the word
task automatic fillTable();
    addRow(32'h00000073, ctl(3'b100, srcAFwd, srcBFwd, 4'h0, wbAlu, pcUtvec, aluNull, tyNone));
    addRow(32'h00100073, ctl(3'b010, srcAFwd, srcBFwd, 4'h0, wbAlu, pcPlus4, aluNull, tyNone));
    addRow(32'h00200073, ctl(3'b000, srcAFwd, srcBFwd, 4'h0, wbAlu, pcUepc, aluNull, tyNone));
    addRow(32'h300110F3, ctl(3'd0, srcAFwd, srcBZero, 4'hC, wbCsr, pcPlus4, aluAdd, tyCsr));
    addRow(32'h300120F3, ctl(3'd0, srcAFwd, srcBFwd, 4'hC, wbCsr, pcPlus4, aluOr, tyCsr));
    addRow(32'h300130F3, ctl(3'd0, srcAInv, srcBFwd, 4'hC, wbCsr, pcPlus4, aluAnd, tyCsr));
    addRow(32'h300150F3, ctl(3'd0, srcAImm, srcBZero, 4'hC, wbCsr, pcPlus4, aluAdd, tyCsr));
    addRow(32'h300160F3, ctl(3'd0, srcAImm, srcBFwd, 4'hC, wbCsr, pcPlus4, aluOr, tyCsr));
    addRow(32'h300170F3, ctl(3'd0, srcAImm, srcBFwd, 4'hC, wbCsr, pcPlus4, aluAnd, tyCsr));
    // OP and OP-IMM
    addRow(32'h003100B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluAdd, tyR));
    addRow(32'h403100B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluSub, tyR));
    addRow(32'h003110B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluSll, tyR));
    addRow(32'h003120B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluSlt, tyR));
    addRow(32'h003130B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluSltu, tyR));
    addRow(32'h003140B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluXor, tyR));
    addRow(32'h003150B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluSrl, tyR));
    addRow(32'h403150B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluSra, tyR));
    addRow(32'h003160B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluOr, tyR));
    addRow(32'h003170B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluAnd, tyR));
    addRow(32'h00510093, ctl(3'd0, srcAFwd, srcBImm, 4'h8, wbAlu, pcPlus4, aluAdd, tyI));
    addRow(32'h40315093, ctl(3'd0, srcAFwd, srcBImm, 4'h8, wbAlu, pcPlus4, aluSra, tyI));
    addRow(32'h0FF17093, ctl(3'd0, srcAFwd, srcBImm, 4'h8, wbAlu, pcPlus4, aluAnd, tyI));
    // M extension
    addRow(32'h023100B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluMul, tyM));
    addRow(32'h023110B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluMulh, tyM));
    addRow(32'h023120B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluMulhsu, tyM));
    addRow(32'h023130B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluMulhu, tyM));
    addRow(32'h023140B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluDiv, tyM));
    addRow(32'h023150B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluDivu, tyM));
    addRow(32'h023160B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluRem, tyM));
    addRow(32'h023170B3, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbAlu, pcPlus4, aluRemu, tyM));
    // Memory, upper immediate and flow
    addRow(32'h00812083, ctl(3'd0, srcAFwd, srcBImm, 4'h9, wbMem, pcPlus4, aluAdd, tyLoad));
    addRow(32'h00312223, ctl(3'd0, srcAFwd, srcBImm, 4'h2, wbAlu, pcPlus4, aluAdd, tyStore));
    addRow(32'h123450B7, ctl(3'd0, srcAFwd, srcBImm, 4'h8, wbAlu, pcPlus4, aluLui, tyI));
    addRow(32'h00001097, ctl(3'd0, srcAPc, srcBImm, 4'h8, wbAlu, pcPlus4, aluAdd, tyI));
    addRow(32'h00310463, ctl(3'd0, srcAFwd, srcBFwd, 4'h0, wbAlu, pcBranch, aluAdd, tyBr));
    addRow(32'h010000EF, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbPc4, pcJal, aluAdd, tyJal));
    addRow(32'h000100E7, ctl(3'd0, srcAFwd, srcBFwd, 4'h8, wbPc4, pcJalr, aluAdd, tyJalr));
    // Invalid encodings
    addRow(32'h003100FF, invOnly());   // Unknown opcode
    addRow(32'h00000000, invOnly());
    addRow(32'h00012007, invOnly());   // Float load is not decoded
    addRow(32'h203100B3, invOnly());   // Bad funct7
    addRow(32'h403110B3, invOnly());   // SUB funct7 with SLL funct3
    addRow(32'h00300073, invOnly());   // Bad funct12
    addRow(32'h00004073, invOnly());   // Bad SYSTEM funct3
endtask

`endif

// ==== test/tb_controlPipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module tb_controlPipe;
    import decodePkg::*;

    localparam int clkPeriod   = 100;
    localparam int driveDelay  = 10;
    localparam int resetCycles = 5;
    localparam int sweepLen    = 200;

    localparam logic [8:0] tyNone  = 9'b000000000;
    localparam logic [8:0] tyCsr   = 9'b100000000;
    localparam logic [8:0] tyM     = 9'b010010000;  // rType with divRem
    localparam logic [8:0] tyLoad  = 9'b001000000;
    localparam logic [8:0] tyStore = 9'b000100000;
    localparam logic [8:0] tyR     = 9'b000010000;
    localparam logic [8:0] tyI     = 9'b000001000;
    localparam logic [8:0] tyJal   = 9'b000000100;
    localparam logic [8:0] tyJalr  = 9'b000000010;
    localparam logic [8:0] tyBr    = 9'b000000001;

    typedef struct packed {
        logic [`INSTR_W-1:0] word;
        ctrlBundle_t         expCtrl;
        stageFields_t        expFields;
    } row_t;

    logic                iCLK;
    logic                rstN;
    logic [`INSTR_W-1:0] instr;
    logic                instrValid;
    logic                stall;
    logic                flush;
    ctrlBundle_t         ctrl;
    stageFields_t        fields;
    logic                ctrlValid;

    row_t rows[$];
    int   checks = 0;
    int   valueErrors = 0;
    int   invariantErrors = 0;
    int   cycles = 0;
    int   cycleLimit = 0;

    controlPipe controlPipe_inst (
        .iCLK       (iCLK),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .flush      (flush),
        .ctrl       (ctrl),
        .fields     (fields),
        .ctrlValid  (ctrlValid)
    );

    function automatic ctrlBundle_t ctl(input logic [2:0] flags, input origA_t a,
            input origB_t b, input logic [3:0] en, input mem2Reg_t wb, input origPc_t pc,
            input aluOp_t op, input logic [8:0] ty);
        ctrlBundle_t c;
        c = '0;
        {c.ecall, c.ebreak, c.invInstr} = flags;
        c.origA = a;
        c.origB = b;
        {c.regWrite, c.csRegWrite, c.memWrite, c.memRead} = en;
        c.mem2Reg = wb;
        c.origPc = pc;
        c.aluControl = op;
        c.instrType = ty;
        return c;
    endfunction

    function automatic ctrlBundle_t invOnly();
        ctrlBundle_t c;
        c = '0;
        c.invInstr = 1'b1;
        return c;
    endfunction

    // RISC-V register and funct3 positions
    function automatic stageFields_t sliceFields(input logic [`INSTR_W-1:0] w);
        stageFields_t f;
        f.rd = w[11:7];
        f.rs1 = w[19:15];
        f.rs2 = w[24:20];
        f.funct3 = w[14:12];
        return f;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic addRow(input logic [`INSTR_W-1:0] word, input ctrlBundle_t expCtrl);
        row_t r;
        r.word = word;
        r.expCtrl = expCtrl;
        r.expFields = sliceFields(word);
        rows.push_back(r);
    endtask

    `include "controlTable.svh"

    task automatic nextCycle();
        @(posedge iCLK);
        #driveDelay;
    endtask

    task automatic checkOut(input ctrlBundle_t expCtrl, input stageFields_t expFields,
            input logic expValid, input string what);
        checks++;
        assert (ctrl == expCtrl && fields == expFields && ctrlValid == expValid) else begin
            valueErrors++;
            $display("Fail %0t: %s ctrl %h (exp %h) fields %h (exp %h) valid %b (exp %b)",
                $time, what, ctrl, expCtrl, fields, expFields, ctrlValid, expValid);
        end
    endtask

    task automatic checkInvariants(input logic [`INSTR_W-1:0] word);
        checks++;
        assert (!(ctrl.memRead && ctrl.memWrite)) else begin
            invariantErrors++;
            $display("Fail %0t: word %h sets memRead and memWrite", $time, word);
        end
        assert (!ctrl.invInstr ||
                !(ctrl.regWrite || ctrl.csRegWrite || ctrl.memWrite || ctrl.memRead)) else begin
            invariantErrors++;
            $display("Fail %0t: invalid word %h has an enable set", $time, word);
        end
        assert (fields == sliceFields(word) && ctrlValid) else begin
            invariantErrors++;
            $display("Fail %0t: word %h gives fields %h valid %b", $time, word, fields, ctrlValid);
        end
    endtask

    task automatic printSummary();
        $display("Checks %0d, value errors %0d, invariant errors %0d",
            checks, valueErrors, invariantErrors);
    endtask

    initial begin
        iCLK = 1'b0;
        forever #(clkPeriod / 2) iCLK = ~iCLK;
    end

    // Watchdog
    initial begin
        wait (cycleLimit != 0);
        while (cycles < cycleLimit) begin
            @(posedge iCLK);
            cycles++;
        end
        $display("Timeout: run still busy after %0d cycles", cycles);
        printSummary();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int          i;
        row_t        last;
        logic [31:0] seed;
        rstN = 1'b0;
        fillTable();
        instr = rows[0].word;   // Valid word held off by reset
        instrValid = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        seed = 32'h8845;
        cycleLimit = rows.size() + sweepLen + 50;

        repeat (resetCycles) @(posedge iCLK);
        #driveDelay;
        rstN = 1'b1;
        checkOut('0, '0, 1'b0, "after reset");

        for (i = 0; i < rows.size(); i++) begin
            instr = rows[i].word;
            instrValid = 1'b1;
            nextCycle();
            checkOut(rows[i].expCtrl, rows[i].expFields, 1'b1, $sformatf("row %0d", i));
        end

        // New words during a stall are dropped
        last = rows[rows.size() - 1];
        stall = 1'b1;
        for (i = 0; i < 3; i++) begin
            instr = rows[i].word;
            nextCycle();
            checkOut(last.expCtrl, last.expFields, 1'b1, "stall hold");
        end
        stall = 1'b0;

        flush = 1'b1;
        nextCycle();
        checkOut('0, '0, 1'b0, "flush");
        flush = 1'b0;
        instr = rows[1].word;
        nextCycle();
        checkOut(rows[1].expCtrl, rows[1].expFields, 1'b1, "after flush");
        instrValid = 1'b0;
        nextCycle();
        checkOut('0, '0, 1'b0, "instrValid low");
        instrValid = 1'b1;
        instr = rows[2].word;
        nextCycle();
        checkOut(rows[2].expCtrl, rows[2].expFields, 1'b1, "refill");
        stall = 1'b1;
        flush = 1'b1;
        nextCycle();
        checkOut('0, '0, 1'b0, "flush over stall");
        stall = 1'b0;
        flush = 1'b0;

        for (i = 0; i < sweepLen; i++) begin
            seed = xorshift(seed);
            instr = seed;
            nextCycle();
            checkInvariants(seed);
        end

        printSummary();
        if (valueErrors == 0 && invariantErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/controlPipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module controlPipe (
    input  logic                    iCLK,
    input  logic                    rstN,
    input  logic [`INSTR_W-1:0]     instr,
    input  logic                    instrValid,
    input  logic                    stall,
    input  logic                    flush,
    output decodePkg::ctrlBundle_t  ctrl,
    output decodePkg::stageFields_t fields,
    output logic                    ctrlValid
);
    import decodePkg::*;

    instrFields_t decFields;
    stageFields_t regFields;
    ctrlBundle_t  sysCtrl;
    ctrlBundle_t  aluCtrl;
    ctrlBundle_t  flowCtrl;
    ctrlBundle_t  merged;
    logic         sysHit;
    logic         aluHit;
    logic         flowHit;

    assign decFields.opcode = instr[6:0];
    assign decFields.funct3 = instr[14:12];
    assign decFields.funct7 = instr[31:25];

    assign regFields.rd     = instr[11:7];
    assign regFields.rs1    = instr[19:15];
    assign regFields.rs2    = instr[24:20];
    assign regFields.funct3 = instr[14:12];

    systemDecode systemDecode_inst (
        .fields  (decFields),
        .funct12 (instr[31:20]),
        .hit     (sysHit),
        .ctrl    (sysCtrl)
    );

    intAluDecode intAluDecode_inst (
        .fields (decFields),
        .hit    (aluHit),
        .ctrl   (aluCtrl)
    );

    flowMemDecode flowMemDecode_inst (
        .fields (decFields),
        .hit    (flowHit),
        .ctrl   (flowCtrl)
    );

    // Idle decoders drive zero, so OR is the merge
    always_comb begin
        merged          = ctrlBundle_t'(sysCtrl | aluCtrl | flowCtrl);
        merged.invInstr = merged.invInstr | !(sysHit || aluHit || flowHit);
    end

    pipeStageReg #(.payload_t(ctrlBundle_t)) ctrlStage_inst (
        .iCLK    (iCLK),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .inValid (instrValid),
        .d       (merged),
        .q       (ctrl),
        .qValid  (ctrlValid)
    );

    pipeStageReg #(.payload_t(stageFields_t)) fieldStage_inst (
        .iCLK    (iCLK),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .inValid (instrValid),
        .d       (regFields),
        .q       (fields),
        .qValid  ()            // Tracks ctrlValid
    );

    aOneClass: assert property (@(posedge iCLK) disable iff (!rstN)
        $onehot0({sysHit, aluHit, flowHit}))
        else $error("controlPipe: opcode claimed by more than one decoder");

endmodule

`default_nettype wire

// ==== hdl/pipeStageReg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeStageReg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     iCLK,
    input  logic     rstN,
    input  logic     stall,
    input  logic     flush,
    input  logic     inValid,
    input  payload_t d,
    output payload_t q,
    output logic     qValid
);

    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            q      <= '0;
            qValid <= 1'b0;
        end else if (flush || (!stall && !inValid)) begin
            q      <= '0;    // Bubble
            qValid <= 1'b0;
        end else if (!stall) begin
            q      <= d;
            qValid <= 1'b1;
        end
    end

    // Flush overrides a stall in the same cycle
    aFlushBubble: assert property (@(posedge iCLK) disable iff (!rstN)
        flush |=> !qValid)
        else $error("pipeStageReg: valid data after a flush");

endmodule

`default_nettype wire

// ==== hdl/flowMemDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module flowMemDecode (
    input  decodePkg::instrFields_t  fields,
    output logic                     hit,
    output decodePkg::ctrlBundle_t   ctrl
);
    import decodePkg::*;

    always_comb begin
        hit  = 1'b1;
        ctrl = '0;
        case (fields.opcode)
            `OPC_LOAD: begin
                ctrl.origB          = srcBImm;
                ctrl.regWrite       = 1'b1;
                ctrl.memRead        = 1'b1;
                ctrl.aluControl     = aluAdd;   // Address = rs1 + imm
                ctrl.mem2Reg        = wbMem;
                ctrl.instrType.load = 1'b1;
            end
            `OPC_STORE: begin
                ctrl.origB           = srcBImm;
                ctrl.memWrite        = 1'b1;
                ctrl.aluControl      = aluAdd;
                ctrl.instrType.store = 1'b1;
            end
            `OPC_LUI: begin
                ctrl.origB           = srcBImm;
                ctrl.regWrite        = 1'b1;
                ctrl.aluControl      = aluLui;
                ctrl.instrType.iType = 1'b1;
            end
            `OPC_AUIPC: begin
                ctrl.origA           = srcAPc;
                ctrl.origB           = srcBImm;
                ctrl.regWrite        = 1'b1;
                ctrl.aluControl      = aluAdd;
                ctrl.instrType.iType = 1'b1;
            end
            `OPC_BRANCH: begin
                ctrl.aluControl       = aluAdd;
                ctrl.origPc           = pcBranch;
                ctrl.instrType.branch = 1'b1;
            end
            `OPC_JAL: begin
                ctrl.regWrite      = 1'b1;
                ctrl.aluControl    = aluAdd;
                ctrl.mem2Reg       = wbPc4;   // Link address
                ctrl.origPc        = pcJal;
                ctrl.instrType.jal = 1'b1;
            end
            `OPC_JALR: begin
                ctrl.regWrite       = 1'b1;
                ctrl.aluControl     = aluAdd;
                ctrl.mem2Reg        = wbPc4;
                ctrl.origPc         = pcJalr;
                ctrl.instrType.jalr = 1'b1;
            end
            default: hit = 1'b0;
        endcase
    end

    aMemExcl: assert property (@(fields) !(ctrl.memRead && ctrl.memWrite))
        else $error("flowMemDecode: memRead and memWrite both set");

endmodule

`default_nettype wire

// ==== hdl/intAluDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module intAluDecode (
    input  decodePkg::instrFields_t  fields,
    output logic                     hit,
    output decodePkg::ctrlBundle_t   ctrl
);
    import decodePkg::*;

    aluOp_t baseOp;
    aluOp_t mulOp;
    logic   isAlt;   // SUB or SRA form of funct7
    logic   altOk;

    assign isAlt = (fields.funct7 == `FUNCT7_SUB);
    assign altOk = (fields.funct3 == `FUNCT3_ADD) || (fields.funct3 == `FUNCT3_SRL);

    // Shared by OP and OP-IMM
    always_comb begin
        case (fields.funct3)
            `FUNCT3_ADD:  baseOp = aluAdd;
            `FUNCT3_SLL:  baseOp = aluSll;
            `FUNCT3_SLT:  baseOp = aluSlt;
            `FUNCT3_SLTU: baseOp = aluSltu;
            `FUNCT3_XOR:  baseOp = aluXor;
            `FUNCT3_SRL:  baseOp = isAlt ? aluSra : aluSrl;
            `FUNCT3_OR:   baseOp = aluOr;
            `FUNCT3_AND:  baseOp = aluAnd;
            default:      baseOp = aluNull;
        endcase
    end

    always_comb begin
        case (fields.funct3)
            `FUNCT3_MUL:    mulOp = aluMul;
            `FUNCT3_MULH:   mulOp = aluMulh;
            `FUNCT3_MULHSU: mulOp = aluMulhsu;
            `FUNCT3_MULHU:  mulOp = aluMulhu;
            `FUNCT3_DIV:    mulOp = aluDiv;
            `FUNCT3_DIVU:   mulOp = aluDivu;
            `FUNCT3_REM:    mulOp = aluRem;
            `FUNCT3_REMU:   mulOp = aluRemu;
            default:        mulOp = aluNull;
        endcase
    end

    always_comb begin
        hit  = 1'b0;
        ctrl = '0;
        case (fields.opcode)
            `OPC_OPIMM: begin
                hit                  = 1'b1;
                ctrl.origB           = srcBImm;
                ctrl.regWrite        = 1'b1;
                ctrl.aluControl      = baseOp;   // Upper imm bits only matter for SRAI
                ctrl.instrType.iType = 1'b1;
            end
            `OPC_RTYPE: begin
                hit = 1'b1;
                if (fields.funct7 == `FUNCT7_MULDIV) begin
                    ctrl.regWrite         = 1'b1;
                    ctrl.aluControl       = mulOp;
                    ctrl.instrType.rType  = 1'b1;
                    ctrl.instrType.divRem = 1'b1;
                end else if (fields.funct7 == `FUNCT7_ADD || (isAlt && altOk)) begin
                    ctrl.regWrite        = 1'b1;
                    ctrl.aluControl      = (isAlt && fields.funct3 == `FUNCT3_ADD) ? aluSub
                                                                                   : baseOp;
                    ctrl.instrType.rType = 1'b1;
                end else begin
                    ctrl.invInstr = 1'b1;   // Bad funct7 or funct3 pairing
                end
            end
            default: ;
        endcase
    end

    aNoHitIdle: assert property (@(fields) !hit |-> (ctrl == '0))
        else $error("intAluDecode: controls driven without an opcode hit");

endmodule

`default_nettype wire

// ==== hdl/systemDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module systemDecode (
    input  decodePkg::instrFields_t  fields,
    input  logic [`FUNCT12_W-1:0]    funct12,
    output logic                     hit,
    output decodePkg::ctrlBundle_t   ctrl
);
    import decodePkg::*;

    always_comb begin
        logic csrForm;
        csrForm = 1'b0;
        hit     = (fields.opcode == `OPC_SYSTEM);
        ctrl    = '0;
        if (hit) begin
            case (fields.funct3)
                `FUNCT3_PRIV: begin
                    case (funct12)
                        `FUNCT12_ECALL: begin
                            ctrl.ecall  = 1'b1;
                            ctrl.origPc = pcUtvec;
                        end
                        `FUNCT12_EBREAK: ctrl.ebreak = 1'b1;
                        `FUNCT12_URET:   ctrl.origPc = pcUepc;
                        default:         ctrl.invInstr = 1'b1;
                    endcase
                end
                `FUNCT3_CSRRW: begin
                    csrForm         = 1'b1;
                    ctrl.origB      = srcBZero; // Pass rs1 through
                    ctrl.aluControl = aluAdd;
                end
                `FUNCT3_CSRRS: begin
                    csrForm         = 1'b1;
                    ctrl.aluControl = aluOr;
                end
                `FUNCT3_CSRRC: begin
                    csrForm         = 1'b1;
                    ctrl.origA      = srcAInv;  // csr & ~rs1
                    ctrl.aluControl = aluAnd;
                end
                `FUNCT3_CSRRWI: begin
                    csrForm         = 1'b1;
                    ctrl.origA      = srcAImm;
                    ctrl.origB      = srcBZero;
                    ctrl.aluControl = aluAdd;
                end
                `FUNCT3_CSRRSI: begin
                    csrForm         = 1'b1;
                    ctrl.origA      = srcAImm;
                    ctrl.aluControl = aluOr;
                end
                `FUNCT3_CSRRCI: begin
                    csrForm         = 1'b1;
                    ctrl.origA      = srcAImm;  // Same source code as CSRRSI
                    ctrl.aluControl = aluAnd;
                end
                default: ctrl.invInstr = 1'b1;
            endcase
        end
        if (csrForm) begin
            ctrl.regWrite      = 1'b1;
            ctrl.csRegWrite    = 1'b1;
            ctrl.mem2Reg       = wbCsr;
            ctrl.instrType.csr = 1'b1;
        end
    end

    aInvNoWrite: assert property (@(fields)
        ctrl.invInstr |-> !(ctrl.regWrite || ctrl.csRegWrite || ctrl.memWrite))
        else $error("systemDecode: invalid SYSTEM word with a write enable");

endmodule

`default_nettype wire

// ==== hdl/decodePkg.sv ====
`default_nettype none

`include "decode_params.svh"

package decodePkg;

    typedef enum logic [4:0] {
        aluNull   = 5'd0,
        aluAdd    = 5'd1,
        aluSub    = 5'd2,
        aluSll    = 5'd3,
        aluSlt    = 5'd4,
        aluSltu   = 5'd5,
        aluXor    = 5'd6,
        aluSrl    = 5'd7,
        aluSra    = 5'd8,
        aluOr     = 5'd9,
        aluAnd    = 5'd10,
        aluLui    = 5'd11,
        aluMul    = 5'd12,
        aluMulh   = 5'd13,
        aluMulhsu = 5'd14,
        aluMulhu  = 5'd15,
        aluDiv    = 5'd16,
        aluDivu   = 5'd17,
        aluRem    = 5'd18,
        aluRemu   = 5'd19
    } aluOp_t;

    typedef enum logic [1:0] {
        srcAFwd = 2'b00,
        srcAPc  = 2'b01,
        srcAImm = 2'b10,
        srcAInv = 2'b11   // Inverted forwarded A
    } origA_t;

    typedef enum logic [1:0] {
        srcBFwd  = 2'b00,
        srcBImm  = 2'b01,
        srcBZero = 2'b10
    } origB_t;

    typedef enum logic [2:0] {
        wbAlu = 3'b000,
        wbPc4 = 3'b001,
        wbMem = 3'b010,
        wbFpu = 3'b011,   // Reserved
        wbCsr = 3'b100
    } mem2Reg_t;

    typedef enum logic [2:0] {
        pcPlus4  = 3'b000,
        pcBranch = 3'b001,
        pcJal    = 3'b010,
        pcJalr   = 3'b011,
        pcUepc   = 3'b100,
        pcUtvec  = 3'b101
    } origPc_t;

    typedef struct packed {
        logic csr;
        logic divRem;
        logic load;
        logic store;
        logic rType;
        logic iType;
        logic jal;
        logic jalr;
        logic branch;
    } instrType_t;

    // All zero is a bubble
    typedef struct packed {
        logic       ecall;
        logic       ebreak;
        logic       invInstr;
        origA_t     origA;
        origB_t     origB;
        logic       regWrite;
        logic       csRegWrite;
        logic       memWrite;
        logic       memRead;
        mem2Reg_t   mem2Reg;
        origPc_t    origPc;
        aluOp_t     aluControl;
        instrType_t instrType;
    } ctrlBundle_t;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`FUNCT3_W-1:0] funct3;
        logic [`FUNCT7_W-1:0] funct7;
    } instrFields_t;

    typedef struct packed {
        logic [`REG_W-1:0]    rd;
        logic [`REG_W-1:0]    rs1;
        logic [`REG_W-1:0]    rs2;
        logic [`FUNCT3_W-1:0] funct3;
    } stageFields_t;

endpackage

`default_nettype wire

// ==== hdl/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Field widths
`define INSTR_W         32
`define OPCODE_W        7
`define FUNCT3_W        3
`define FUNCT7_W        7
`define FUNCT12_W       12
`define REG_W           5

// Integer subset opcodes
`define OPC_LOAD        7'b0000011
`define OPC_OPIMM       7'b0010011
`define OPC_AUIPC       7'b0010111
`define OPC_STORE       7'b0100011
`define OPC_RTYPE       7'b0110011
`define OPC_LUI         7'b0110111
`define OPC_BRANCH      7'b1100011
`define OPC_JALR        7'b1100111
`define OPC_JAL         7'b1101111
`define OPC_SYSTEM      7'b1110011

// SYSTEM funct3
`define FUNCT3_PRIV     3'b000
`define FUNCT3_CSRRW    3'b001
`define FUNCT3_CSRRS    3'b010
`define FUNCT3_CSRRC    3'b011
`define FUNCT3_CSRRWI   3'b101
`define FUNCT3_CSRRSI   3'b110
`define FUNCT3_CSRRCI   3'b111

// OP and OP-IMM funct3
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL      3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// M extension funct3
`define FUNCT3_MUL      3'b000
`define FUNCT3_MULH     3'b001
`define FUNCT3_MULHSU   3'b010
`define FUNCT3_MULHU    3'b011
`define FUNCT3_DIV      3'b100
`define FUNCT3_DIVU     3'b101
`define FUNCT3_REM      3'b110
`define FUNCT3_REMU     3'b111

`define FUNCT7_ADD      7'b0000000
`define FUNCT7_SUB      7'b0100000 // Also selects SRA
`define FUNCT7_MULDIV   7'b0000001

`define FUNCT12_ECALL   12'h000
`define FUNCT12_EBREAK  12'h001
`define FUNCT12_URET    12'h002

`endif
